// ==== i3c.f ====
i3c_csr_pkg.sv
i3c_proto_pkg.sv
i3c_queue.sv
i3c_csr_regs.sv
i3c_ctrl.sv
i3c_phy.sv
i3c.sv
i3c_target.sv
tb_i3c.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the I3C controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
  --top-module tb_i3c -f i3c.f -o sim_i3c
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

./obj_dir/sim_i3c > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0

// ==== tb_i3c.sv ====
// One target at 0x2A on the bus; CSR accesses start 2 ns after the rising clock edge
module tb_i3c;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        rst;
  logic        csr_req;
  logic        csr_wr;
  logic [7:0]  csr_addr;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic        csr_rd_ack;
  logic        csr_wr_ack;
  logic        csr_err;
  logic        scl_dut;
  logic        sda_dut;
  logic        sel_od_pp;
  logic        tgt_sda;
  logic        scl_bus;
  logic        sda_bus;
  logic [7:0]  tgt_byte;
  int          tgt_errs;
  int          errors;
  int          checks;
  int          tests;
  int          err_base;
  int          sel_errs = 0;
  int          sel_cycles = 0;

  // Open-drain lines where the target never holds SCL
  assign scl_bus = scl_dut;
  assign sda_bus = sda_dut & tgt_sda;

  i3c DUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .csr_req_i   (csr_req),
    .csr_wr_i    (csr_wr),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .csr_rd_ack_o(csr_rd_ack),
    .csr_wr_ack_o(csr_wr_ack),
    .csr_err_o   (csr_err),
    .scl_i       (scl_bus),
    .sda_i       (sda_bus),
    .scl_o       (scl_dut),
    .sda_o       (sda_dut),
    .sel_od_pp_o (sel_od_pp)
  );

  i3c_target #(
    .Addr(7'h2A)
  ) u_target (
    .clk_i   (clk),
    .rst_i   (rst),
    .scl_i   (scl_bus),
    .sda_i   (sda_bus),
    .sda_o   (tgt_sda),
    .stored_o(tgt_byte),
    .errs_o  (tgt_errs)
  );

  always #20 clk = ~clk;

  // Cycles with push-pull selected on the pins
  always @(posedge clk) begin
    if (sel_od_pp === 1'b1) begin
      sel_cycles <= sel_cycles + 1;
    end
  end

  // Push-pull drive must never meet a target pulling SDA low
  assert property (@(posedge clk) disable iff (rst) sel_od_pp |-> tgt_sda)
  else begin
    $display("bus: push-pull select was high while the target pulled SDA low");
    sel_errs++;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Called 2 ns after an edge and returns 2 ns after the acknowledge edge
  task automatic csr_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    csr_req   = 1'b1;
    csr_wr    = wr;
    csr_addr  = addr;
    csr_wdata = wdata;
    @(posedge clk);
    #2;
    csr_req = 1'b0;
    n = 0;
    while (!(csr_wr_ack || csr_rd_ack) && n < 10) begin
      @(posedge clk);
      #2;
      n++;
    end
    rdata = csr_rdata;
    err   = csr_err;
    if (!(csr_wr_ack || csr_rd_ack)) begin
      $display("timeout: no CSR acknowledge for address 0x%h within 10 cycles", addr);
      errors++;
    end else begin
      check_value("csr_wr_ack_o", 32'(csr_wr_ack), 32'(wr));
      check_value("csr_rd_ack_o", 32'(csr_rd_ack), 32'(!wr));
    end
  endtask

  task automatic csr_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
    logic [31:0] unused_rd;
    csr_access(1'b1, addr, wdata, unused_rd, err);
  endtask

  task automatic csr_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
    csr_access(1'b0, addr, 32'd0, rdata, err);
  endtask

  // Poll until a response is queued, then pop it
  task automatic get_response(output logic [31:0] resp);
    logic [31:0] st;
    logic        err;
    int          cycles;
    cycles = 0;
    st     = '1;
    while (st[i3c_csr_pkg::QST_RESP_EMPTY] && cycles < 2000) begin
      csr_read(i3c_csr_pkg::QUEUE_STATUS_ADDR, st, err);
      cycles++;
    end
    if (st[i3c_csr_pkg::QST_RESP_EMPTY]) begin
      $display("timeout: no response queued within 2000 cycles");
      errors++;
    end
    csr_read(i3c_csr_pkg::RESP_PORT_ADDR, resp, err);
    check_value("resp_port csr_err", 32'(err), 32'd0);
  endtask

  // Descriptor fields are data 20:13, addr 12:6, tid 5:2 and attr 1:0
  function automatic logic [31:0] make_cmd(input logic [1:0] attr, input logic [3:0] tid,
                                           input logic [6:0] addr, input logic [7:0] data);
    make_cmd = {11'd0, data, addr, tid, attr};
  endfunction

  task automatic report_test(input string name);
    int now_errs;
    now_errs = errors + tgt_errs + sel_errs;
    tests++;
    if (now_errs == err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, now_errs - err_base);
    end
    err_base = now_errs;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [31:0] exp;
    logic        err;
    logic [7:0]  wbyte;
    logic [3:0]  tid;
    logic [3:0]  tids [5];
    int          sel_seen;
    int          total_errs;

    void'($urandom(32'h64799e08));
    clk       = 1'b0;
    rst       = 1'b1;
    csr_req   = 1'b0;
    csr_wr    = 1'b0;
    csr_addr  = 8'd0;
    csr_wdata = 32'd0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    err_base  = 0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    // Reset state
    check_value("scl_o", 32'(scl_dut), 32'd1);
    check_value("sda_o", 32'(sda_dut), 32'd1);
    check_value("sel_od_pp_o", 32'(sel_od_pp), 32'd0);
    check_value("csr_rd_ack_o", 32'(csr_rd_ack), 32'd0);
    csr_read(i3c_csr_pkg::QUEUE_STATUS_ADDR, rd, err);
    exp = 32'd0;
    exp[i3c_csr_pkg::QST_CMD_EMPTY]  = 1'b1;
    exp[i3c_csr_pkg::QST_RESP_EMPTY] = 1'b1;
    check_value("queue_status", rd, exp);
    csr_read(i3c_csr_pkg::BUS_TIMING_ADDR, rd, err);
    check_value("bus_timing", rd, 32'd8);
    report_test("reset_defaults");

    // Immediate write to the target
    csr_write(i3c_csr_pkg::CTRL_ADDR, 32'd1, err);
    check_value("ctrl csr_err", 32'(err), 32'd0);
    rnd   = $urandom();
    wbyte = rnd[7:0];
    tid   = rnd[11:8];
    csr_write(i3c_csr_pkg::CMD_PORT_ADDR, make_cmd(2'd1, tid, 7'h2A, wbyte), err);
    check_value("cmd_port csr_err", 32'(err), 32'd0);
    get_response(rd);
    check_value("resp tid", 32'(rd[3:0]), 32'(tid));
    check_value("resp status", 32'(rd[7:4]), 32'd0);
    check_value("target byte", 32'(tgt_byte), 32'(wbyte));
    check_value("sel_od_pp_o seen high", 32'(sel_cycles != 0), 32'd1);
    report_test("imm_write");

    // Read back the stored byte
    sel_seen = sel_cycles;
    rnd = $urandom();
    tid = rnd[3:0];
    csr_write(i3c_csr_pkg::CMD_PORT_ADDR, make_cmd(2'd2, tid, 7'h2A, 8'd0), err);
    get_response(rd);
    check_value("resp tid", 32'(rd[3:0]), 32'(tid));
    check_value("resp status", 32'(rd[7:4]), 32'd0);
    check_value("resp data", 32'(rd[15:8]), 32'(wbyte));
    check_value("sel_od_pp_o cycles in read", 32'(sel_cycles), 32'(sel_seen));
    report_test("read");

    // Unknown bus address, then a bad attr
    rnd = $urandom();
    tid = rnd[3:0];
    csr_write(i3c_csr_pkg::CMD_PORT_ADDR, make_cmd(2'd1, tid, 7'h15, ~wbyte), err);
    get_response(rd);
    check_value("resp tid", 32'(rd[3:0]), 32'(tid));
    check_value("resp status", 32'(rd[7:4]), 32'd1);
    check_value("target byte", 32'(tgt_byte), 32'(wbyte));
    tid = rnd[7:4];
    csr_write(i3c_csr_pkg::CMD_PORT_ADDR, make_cmd(2'd0, tid, 7'h2A, 8'd0), err);
    get_response(rd);
    check_value("resp tid", 32'(rd[3:0]), 32'(tid));
    check_value("resp status", 32'(rd[7:4]), 32'd3);
    report_test("nack_and_bad_cmd");

    // CSR errors, then a full command queue drained in order
    csr_read(i3c_csr_pkg::RESP_PORT_ADDR, rd, err);
    check_value("empty resp_port csr_err", 32'(err), 32'd1);
    check_value("empty resp_port rdata", rd, 32'd0);
    csr_read(8'h20, rd, err);
    check_value("unknown address csr_err", 32'(err), 32'd1);
    csr_write(i3c_csr_pkg::CTRL_ADDR, 32'd0, err);
    for (int i = 0; i < 5; i++) begin
      rnd     = $urandom();
      tids[i] = rnd[3:0];
      csr_write(i3c_csr_pkg::CMD_PORT_ADDR, make_cmd(2'd1, tids[i], 7'h2A, rnd[15:8]), err);
      check_value("queued write csr_err", 32'(err), (i == 4) ? 32'd1 : 32'd0);
    end
    csr_write(i3c_csr_pkg::CTRL_ADDR, 32'd1, err);
    for (int i = 0; i < 4; i++) begin
      get_response(rd);
      check_value("queued resp tid", 32'(rd[3:0]), 32'(tids[i]));
      check_value("queued resp status", 32'(rd[7:4]), 32'd0);
    end
    report_test("errors_and_backpressure");

    total_errs = errors + tgt_errs + sel_errs;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, total_errs);
    if (total_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== i3c_target.sv ====
// Clocked target model sampling the resolved bus each cycle; 7-bit address, no SCL stretching
module i3c_target #(
  parameter logic [6:0] Addr = 7'h2A
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output logic       sda_o,
  output logic [7:0] stored_o,
  output int         errs_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic       scl_q;
  logic       sda_q;
  logic       active_q;
  // 0 address byte, 1 data byte, 2 waiting for STOP
  logic [1:0] phase_q;
  logic [3:0] bit_cnt_q;
  logic       ack_q;
  logic       rnw_q;
  logic [7:0] shift_q;
  logic       scl_rise;
  logic       scl_fall;
  logic       start_seen;
  logic       stop_seen;
  int         bus_errs = 0;

  assign scl_rise   = scl_i && !scl_q;
  assign scl_fall   = !scl_i && scl_q;
  assign start_seen = scl_i && scl_q && sda_q && !sda_i;
  assign stop_seen  = scl_i && scl_q && !sda_q && sda_i;
  assign errs_o     = bus_errs;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      active_q  <= 1'b0;
      phase_q   <= 2'd0;
      bit_cnt_q <= 4'd0;
      ack_q     <= 1'b0;
      rnw_q     <= 1'b0;
      shift_q   <= 8'd0;
      sda_o     <= 1'b1;
      stored_o  <= 8'd0;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
      if (start_seen && !active_q) begin
        active_q  <= 1'b1;
        phase_q   <= 2'd0;
        bit_cnt_q <= 4'd0;
        ack_q     <= 1'b0;
      end else if (stop_seen) begin
        active_q <= 1'b0;
        sda_o    <= 1'b1;
      end else if (active_q && scl_rise && !ack_q && phase_q != 2'd2) begin
        // Bits are taken MSB first on the rising edge
        shift_q   <= {shift_q[6:0], sda_i};
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end else if (active_q && scl_fall) begin
        if (ack_q) begin
          ack_q     <= 1'b0;
          bit_cnt_q <= 4'd0;
          if (phase_q == 2'd0 && shift_q[7:1] == Addr) begin
            phase_q <= 2'd1;
            // First read bit goes out as the ACK slot ends
            sda_o   <= rnw_q ? stored_o[7] : 1'b1;
          end else begin
            phase_q <= 2'd2;
            sda_o   <= 1'b1;
          end
        end else if (bit_cnt_q == 4'd8) begin
          ack_q <= 1'b1;
          if (phase_q == 2'd0) begin
            rnw_q <= shift_q[0];
            sda_o <= (shift_q[7:1] != Addr);
          end else if (!rnw_q) begin
            stored_o <= shift_q;
            sda_o    <= 1'b0;
          end else begin
            // Controller owns the ACK slot after read data
            sda_o <= 1'b1;
          end
        end else if (phase_q == 2'd1 && rnw_q) begin
          sda_o <= stored_o[3'd7 - bit_cnt_q[2:0]];
        end
      end
    end
  end

  // SDA may move under a high SCL only as START while idle or as STOP at the end
  assert property (@(posedge clk_i) disable iff (rst_i)
    (scl_i && scl_q && (sda_i != sda_q))
    |-> ((start_seen && !active_q) || (stop_seen && active_q && phase_q == 2'd2)))
  else begin
    $display("bus: SDA changed while SCL was high in the middle of a transfer");
    bus_errs++;
  end

endmodule

// ==== i3c.sv ====
// CSR port exposed directly; pins give wanted bus levels, 1 means released in open drain
module i3c (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           csr_req_i,
  input  logic                           csr_wr_i,
  input  logic [i3c_csr_pkg::CSR_AW-1:0] csr_addr_i,
  input  logic [i3c_csr_pkg::CSR_DW-1:0] csr_wdata_i,
  output logic [i3c_csr_pkg::CSR_DW-1:0] csr_rdata_o,
  output logic                           csr_rd_ack_o,
  output logic                           csr_wr_ack_o,
  output logic                           csr_err_o,
  input  logic                           scl_i,
  input  logic                           sda_i,
  output logic                           scl_o,
  output logic                           sda_o,
  output logic                           sel_od_pp_o
);

  // Command queue
  logic                                  cmd_push;
  logic                                  cmd_pop;
  logic                                  cmd_full;
  logic                                  cmd_empty;
  logic [i3c_csr_pkg::CSR_DW-1:0]        cmd_wdata;
  logic [i3c_csr_pkg::CSR_DW-1:0]        cmd_rdata;

  // Response queue
  logic                                  resp_push;
  logic                                  resp_pop;
  logic                                  resp_full;
  logic                                  resp_empty;
  logic [i3c_csr_pkg::CSR_DW-1:0]        resp_wdata;
  logic [i3c_csr_pkg::CSR_DW-1:0]        resp_rdata;

  logic                                  enable;
  logic [i3c_csr_pkg::HALF_PERIOD_W-1:0] half_period;
  logic                                  phy2ctrl_scl;
  logic                                  phy2ctrl_sda;
  logic                                  ctrl2phy_scl;
  logic                                  ctrl2phy_sda;
  logic                                  ctrl_sel_od_pp;

  i3c_csr_regs u_csr_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .csr_req_i    (csr_req_i),
    .csr_wr_i     (csr_wr_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .cmd_full_i   (cmd_full),
    .cmd_empty_i  (cmd_empty),
    .resp_full_i  (resp_full),
    .resp_empty_i (resp_empty),
    .resp_data_i  (resp_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .csr_rd_ack_o (csr_rd_ack_o),
    .csr_wr_ack_o (csr_wr_ack_o),
    .csr_err_o    (csr_err_o),
    .cmd_push_o   (cmd_push),
    .cmd_data_o   (cmd_wdata),
    .resp_pop_o   (resp_pop),
    .enable_o     (enable),
    .half_period_o(half_period)
  );

  i3c_queue #(
    .Depth(i3c_proto_pkg::CMD_DEPTH),
    .Width(i3c_csr_pkg::CSR_DW)
  ) u_cmd_queue (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .push_i (cmd_push),
    .data_i (cmd_wdata),
    .pop_i  (cmd_pop),
    .data_o (cmd_rdata),
    .full_o (cmd_full),
    .empty_o(cmd_empty)
  );

  i3c_queue #(
    .Depth(i3c_proto_pkg::RESP_DEPTH),
    .Width(i3c_csr_pkg::CSR_DW)
  ) u_resp_queue (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .push_i (resp_push),
    .data_i (resp_wdata),
    .pop_i  (resp_pop),
    .data_o (resp_rdata),
    .full_o (resp_full),
    .empty_o(resp_empty)
  );

  i3c_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .enable_i     (enable),
    .half_period_i(half_period),
    .cmd_empty_i  (cmd_empty),
    .cmd_data_i   (cmd_rdata),
    .resp_full_i  (resp_full),
    .scl_i        (phy2ctrl_scl),
    .sda_i        (phy2ctrl_sda),
    .cmd_pop_o    (cmd_pop),
    .resp_push_o  (resp_push),
    .resp_data_o  (resp_wdata),
    .scl_o        (ctrl2phy_scl),
    .sda_o        (ctrl2phy_sda),
    .sel_od_pp_o  (ctrl_sel_od_pp)
  );

  i3c_phy u_phy (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .scl_o           (scl_o),
    .sda_o           (sda_o),
    .sel_od_pp_o     (sel_od_pp_o),
    .ctrl_scl_i      (ctrl2phy_scl),
    .ctrl_sda_i      (ctrl2phy_sda),
    .ctrl_sel_od_pp_i(ctrl_sel_od_pp),
    .ctrl_scl_o      (phy2ctrl_scl),
    .ctrl_sda_o      (phy2ctrl_sda)
  );

endmodule

// ==== i3c_phy.sv ====
// Bus inputs are taken as asynchronous; pins idle released with open-drain selected
module i3c_phy (
  input  logic clk_i,
  input  logic rst_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,
  output logic sel_od_pp_o,
  input  logic ctrl_scl_i,
  input  logic ctrl_sda_i,
  input  logic ctrl_sel_od_pp_i,
  output logic ctrl_scl_o,
  output logic ctrl_sda_o
);

  // Bit 1 carries SDA, bit 0 carries SCL
  logic [1:0] sync_q1;
  logic [1:0] sync_q2;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1     <= 2'b11;
      sync_q2     <= 2'b11;
      scl_o       <= 1'b1;
      sda_o       <= 1'b1;
      sel_od_pp_o <= 1'b0;
    end else begin
      sync_q1     <= {sda_i, scl_i};
      sync_q2     <= sync_q1;
      // Driver select moves in the same stage as the pins
      scl_o       <= ctrl_scl_i;
      sda_o       <= ctrl_sda_i;
      sel_od_pp_o <= ctrl_sel_od_pp_i;
    end
  end

  assign ctrl_scl_o = sync_q2[0];
  assign ctrl_sda_o = sync_q2[1];

endmodule

// ==== i3c_ctrl.sv ====
// One command in flight; SCL high phases start only once SCL is seen high on the bus
module i3c_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  enable_i,
  input  logic [i3c_csr_pkg::HALF_PERIOD_W-1:0] half_period_i,
  input  logic                                  cmd_empty_i,
  input  logic [i3c_csr_pkg::CSR_DW-1:0]        cmd_data_i,
  input  logic                                  resp_full_i,
  input  logic                                  scl_i,
  input  logic                                  sda_i,
  output logic                                  cmd_pop_o,
  output logic                                  resp_push_o,
  output logic [i3c_csr_pkg::CSR_DW-1:0]        resp_data_o,
  output logic                                  scl_o,
  output logic                                  sda_o,
  output logic                                  sel_od_pp_o
);

  i3c_proto_pkg::cmd_desc_u              head;
  logic [2:0]                            state_q;
  logic [2:0]                            slot_q;
  logic [2:0]                            bit_cnt_q;
  logic [i3c_csr_pkg::HALF_PERIOD_W-1:0] cnt_q;
  logic [7:0]                            shift_q;
  logic [7:0]                            wdata_q;
  logic [3:0]                            tid_q;
  logic [3:0]                            status_q;
  logic                                  is_read_q;
  logic                                  start_cmd;
  logic                                  in_phase;
  logic                                  scl_wait;
  logic                                  tick;

  assign head      = cmd_data_i;
  assign start_cmd = (state_q == i3c_proto_pkg::S_IDLE) && enable_i && !cmd_empty_i
                     && !resp_full_i;
  assign cmd_pop_o = start_cmd;

  // Half-period pacing, held while SCL has not yet risen on the bus
  assign in_phase = (state_q == i3c_proto_pkg::S_START) || (state_q == i3c_proto_pkg::S_LOW)
                    || (state_q == i3c_proto_pkg::S_HIGH) || (state_q == i3c_proto_pkg::S_STOP);
  assign scl_wait = ((state_q == i3c_proto_pkg::S_HIGH) || (state_q == i3c_proto_pkg::S_STOP))
                    && !scl_i;
  assign tick     = in_phase && !scl_wait && (cnt_q >= half_period_i - 1'b1);

  always_ff @(posedge clk_i) begin
    if (rst_i || !in_phase || tick) begin
      cnt_q <= '0;
    end else if (!scl_wait) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= i3c_proto_pkg::S_IDLE;
      slot_q      <= i3c_proto_pkg::SLOT_ADDR;
      bit_cnt_q   <= '0;
      shift_q     <= '0;
      wdata_q     <= '0;
      tid_q       <= '0;
      status_q    <= i3c_proto_pkg::ST_OK;
      is_read_q   <= 1'b0;
      scl_o       <= 1'b1;
      sda_o       <= 1'b1;
      sel_od_pp_o <= 1'b0;
    end else begin
      case (state_q)
        i3c_proto_pkg::S_IDLE: begin
          if (start_cmd) begin
            tid_q     <= head.read.tid;
            status_q  <= i3c_proto_pkg::ST_OK;
            slot_q    <= i3c_proto_pkg::SLOT_ADDR;
            bit_cnt_q <= '0;
            is_read_q <= (head.read.attr == i3c_proto_pkg::ATTR_READ);
            if (head.imm_write.attr == i3c_proto_pkg::ATTR_IMM_WRITE) begin
              shift_q <= {head.imm_write.addr, i3c_proto_pkg::RNW_WRITE};
              wdata_q <= head.imm_write.data;
              state_q <= i3c_proto_pkg::S_START;
            end else if (head.read.attr == i3c_proto_pkg::ATTR_READ) begin
              shift_q <= {head.read.addr, i3c_proto_pkg::RNW_READ};
              state_q <= i3c_proto_pkg::S_START;
            end else begin
              status_q <= i3c_proto_pkg::ST_BAD_CMD;
              state_q  <= i3c_proto_pkg::S_RESP;
            end
          end
        end
        i3c_proto_pkg::S_START: begin
          // SDA falls while SCL is high
          sda_o <= 1'b0;
          if (tick) begin
            scl_o   <= 1'b0;
            state_q <= i3c_proto_pkg::S_LOW;
          end
        end
        i3c_proto_pkg::S_LOW: begin
          // Drive SDA one cycle after SCL fell
          if (cnt_q == '0) begin
            case (slot_q)
              i3c_proto_pkg::SLOT_ADDR: sda_o <= shift_q[7];
              i3c_proto_pkg::SLOT_DATA: sda_o <= is_read_q || shift_q[7];
              i3c_proto_pkg::SLOT_STOP: sda_o <= 1'b0;
              default:                  sda_o <= 1'b1;
            endcase
            sel_od_pp_o <= (slot_q == i3c_proto_pkg::SLOT_DATA) && !is_read_q;
          end
          if (tick) begin
            scl_o   <= 1'b1;
            state_q <= (slot_q == i3c_proto_pkg::SLOT_STOP) ? i3c_proto_pkg::S_STOP
                                                            : i3c_proto_pkg::S_HIGH;
          end
        end
        i3c_proto_pkg::S_HIGH: begin
          if (tick) begin
            scl_o   <= 1'b0;
            state_q <= i3c_proto_pkg::S_LOW;
            case (slot_q)
              i3c_proto_pkg::SLOT_ADDR, i3c_proto_pkg::SLOT_DATA: begin
                shift_q   <= {shift_q[6:0], sda_i};
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (bit_cnt_q == 3'd7) begin
                  slot_q <= slot_q + 1'b1;
                end
              end
              i3c_proto_pkg::SLOT_AACK: begin
                if (sda_i) begin
                  status_q <= i3c_proto_pkg::ST_ADDR_NACK;
                  slot_q   <= i3c_proto_pkg::SLOT_STOP;
                end else begin
                  shift_q <= wdata_q;
                  slot_q  <= i3c_proto_pkg::SLOT_DATA;
                end
              end
              default: begin
                // Read ends with the controller's own NACK
                if (sda_i && !is_read_q) begin
                  status_q <= i3c_proto_pkg::ST_DATA_NACK;
                end
                slot_q <= i3c_proto_pkg::SLOT_STOP;
              end
            endcase
          end
        end
        i3c_proto_pkg::S_STOP: begin
          if (tick) begin
            sda_o   <= 1'b1;
            state_q <= i3c_proto_pkg::S_RESP;
          end
        end
        default: state_q <= i3c_proto_pkg::S_IDLE;
      endcase
    end
  end

  assign resp_push_o = (state_q == i3c_proto_pkg::S_RESP);

  always_comb begin
    resp_data_o = '0;
    resp_data_o[i3c_proto_pkg::RESP_TID_LSB +: i3c_proto_pkg::RESP_TID_W] = tid_q;
    resp_data_o[i3c_proto_pkg::RESP_STATUS_LSB +: i3c_proto_pkg::RESP_STATUS_W] = status_q;
    if (is_read_q && status_q == i3c_proto_pkg::ST_OK) begin
      resp_data_o[i3c_proto_pkg::RESP_DATA_LSB +: i3c_proto_pkg::RESP_DATA_W] = shift_q;
    end
  end

  // SDA may move under a high SCL only for START and STOP
  assert property (@(posedge clk_i) disable iff (rst_i)
    (scl_o && $past(scl_o) && (sda_o != $past(sda_o)))
    |-> ($past(state_q) == i3c_proto_pkg::S_START || $past(state_q) == i3c_proto_pkg::S_STOP));

endmodule

// ==== i3c_csr_regs.sv ====
// One request at a time, no byte enables; refused accesses have no side effect
module i3c_csr_regs (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     csr_req_i,
  input  logic                                     csr_wr_i,
  input  logic [i3c_csr_pkg::CSR_AW-1:0]           csr_addr_i,
  input  logic [i3c_csr_pkg::CSR_DW-1:0]           csr_wdata_i,
  input  logic                                     cmd_full_i,
  input  logic                                     cmd_empty_i,
  input  logic                                     resp_full_i,
  input  logic                                     resp_empty_i,
  input  logic [i3c_csr_pkg::CSR_DW-1:0]           resp_data_i,
  output logic [i3c_csr_pkg::CSR_DW-1:0]           csr_rdata_o,
  output logic                                     csr_rd_ack_o,
  output logic                                     csr_wr_ack_o,
  output logic                                     csr_err_o,
  output logic                                     cmd_push_o,
  output logic [i3c_csr_pkg::CSR_DW-1:0]           cmd_data_o,
  output logic                                     resp_pop_o,
  output logic                                     enable_o,
  output logic [i3c_csr_pkg::HALF_PERIOD_W-1:0]    half_period_o
);

  logic                                  req_err;
  logic                                  wr_ok;
  logic                                  rd_ok;
  logic [i3c_csr_pkg::CSR_DW-1:0]        rd_val;
  logic [i3c_csr_pkg::HALF_PERIOD_W-1:0] timing_wr;

  // Address decode, direction and queue level checks
  always_comb begin
    req_err = 1'b0;
    rd_val  = '0;
    case (csr_addr_i)
      i3c_csr_pkg::CTRL_ADDR: rd_val[i3c_csr_pkg::CTRL_ENABLE] = enable_o;
      i3c_csr_pkg::CMD_PORT_ADDR: req_err = !csr_wr_i || cmd_full_i;
      i3c_csr_pkg::RESP_PORT_ADDR: begin
        req_err = csr_wr_i || resp_empty_i;
        rd_val  = resp_data_i;
      end
      i3c_csr_pkg::QUEUE_STATUS_ADDR: begin
        req_err = csr_wr_i;
        rd_val[i3c_csr_pkg::QST_CMD_EMPTY]  = cmd_empty_i;
        rd_val[i3c_csr_pkg::QST_CMD_FULL]   = cmd_full_i;
        rd_val[i3c_csr_pkg::QST_RESP_EMPTY] = resp_empty_i;
        rd_val[i3c_csr_pkg::QST_RESP_FULL]  = resp_full_i;
      end
      i3c_csr_pkg::BUS_TIMING_ADDR: rd_val[i3c_csr_pkg::HALF_PERIOD_W-1:0] = half_period_o;
      default: req_err = 1'b1;
    endcase
  end

  assign wr_ok      = csr_req_i && csr_wr_i && !req_err;
  assign rd_ok      = csr_req_i && !csr_wr_i && !req_err;
  assign cmd_push_o = wr_ok && (csr_addr_i == i3c_csr_pkg::CMD_PORT_ADDR);
  assign cmd_data_o = csr_wdata_i;
  assign resp_pop_o = rd_ok && (csr_addr_i == i3c_csr_pkg::RESP_PORT_ADDR);

  // Too short a half period would break the ACK sampling window
  assign timing_wr = (csr_wdata_i[i3c_csr_pkg::HALF_PERIOD_W-1:0] < i3c_csr_pkg::BUS_TIMING_MIN)
                   ? i3c_csr_pkg::BUS_TIMING_MIN
                   : csr_wdata_i[i3c_csr_pkg::HALF_PERIOD_W-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_o      <= 1'b0;
      half_period_o <= i3c_csr_pkg::BUS_TIMING_RESET;
      csr_wr_ack_o  <= 1'b0;
      csr_rd_ack_o  <= 1'b0;
      csr_err_o     <= 1'b0;
    end else begin
      csr_wr_ack_o <= csr_req_i && csr_wr_i;
      csr_rd_ack_o <= csr_req_i && !csr_wr_i;
      csr_err_o    <= csr_req_i && req_err;
      if (wr_ok && csr_addr_i == i3c_csr_pkg::CTRL_ADDR) begin
        enable_o <= csr_wdata_i[i3c_csr_pkg::CTRL_ENABLE];
      end
      if (wr_ok && csr_addr_i == i3c_csr_pkg::BUS_TIMING_ADDR) begin
        half_period_o <= timing_wr;
      end
    end
  end

  // Errored reads return zero
  always_ff @(posedge clk_i) begin
    if (csr_req_i && !csr_wr_i) begin
      csr_rdata_o <= rd_ok ? rd_val : '0;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    (csr_wr_ack_o || csr_rd_ack_o) |-> $past(csr_req_i));

endmodule

// ==== i3c_queue.sv ====
// Depth must be at least 2; a push while full or a pop while empty is dropped
module i3c_queue #(
  parameter int Depth = 4,
  parameter int Width = 32
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [Width-1:0]           mem_q [Depth];
  logic [$clog2(Depth)-1:0]   wr_ptr_q;
  logic [$clog2(Depth)-1:0]   rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       wr_en;
  logic                       rd_en;

  assign full_o  = (count_q == ($clog2(Depth + 1))'(Depth));
  assign empty_o = (count_q == '0);
  assign wr_en   = push_i && !full_o;
  assign rd_en   = pop_i && !empty_o;

  // Head is always visible
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Producers and consumers must honour the levels
  assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

// ==== i3c_proto_pkg.sv ====
// Only single-byte private transfers exist; attr values other than 1 and 2 are rejected
package i3c_proto_pkg;

  // Command descriptor, decoded through the view that attr selects
  typedef union packed {
    struct packed {
      logic [10:0] rsvd;
      logic [7:0]  data;
      logic [6:0]  addr;
      logic [3:0]  tid;
      logic [1:0]  attr;
    } imm_write;
    struct packed {
      logic [18:0] rsvd;
      logic [6:0]  addr;
      logic [3:0]  tid;
      logic [1:0]  attr;
    } read;
  } cmd_desc_u;

  localparam logic [1:0] ATTR_IMM_WRITE = 2'd1;
  localparam logic [1:0] ATTR_READ      = 2'd2;

  // Response word layout
  localparam int RESP_TID_LSB    = 0;
  localparam int RESP_TID_W      = 4;
  localparam int RESP_STATUS_LSB = 4;
  localparam int RESP_STATUS_W   = 4;
  localparam int RESP_DATA_LSB   = 8;
  localparam int RESP_DATA_W     = 8;

  localparam logic [3:0] ST_OK        = 4'd0;
  localparam logic [3:0] ST_ADDR_NACK = 4'd1;
  localparam logic [3:0] ST_DATA_NACK = 4'd2;
  localparam logic [3:0] ST_BAD_CMD   = 4'd3;

  localparam int CMD_DEPTH  = 4;
  localparam int RESP_DEPTH = 4;

  // RnW bit after the 7-bit address
  localparam logic RNW_WRITE = 1'b0;
  localparam logic RNW_READ  = 1'b1;

  // Controller FSM states
  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_START = 3'd1;
  localparam logic [2:0] S_LOW   = 3'd2;
  localparam logic [2:0] S_HIGH  = 3'd3;
  localparam logic [2:0] S_STOP  = 3'd4;
  localparam logic [2:0] S_RESP  = 3'd5;

  // Bit slots within a transfer, in bus order
  localparam logic [2:0] SLOT_ADDR = 3'd0;
  localparam logic [2:0] SLOT_AACK = 3'd1;
  localparam logic [2:0] SLOT_DATA = 3'd2;
  localparam logic [2:0] SLOT_DACK = 3'd3;
  localparam logic [2:0] SLOT_STOP = 3'd4;

endpackage

// ==== i3c_csr_pkg.sv ====
// Byte addresses are decoded on all CSR_AW bits; BUS_TIMING keeps only its low 16 bits
package i3c_csr_pkg;

  localparam int CSR_DW = 32;
  localparam int CSR_AW = 8;

  // Register byte addresses
  localparam logic [CSR_AW-1:0] CTRL_ADDR         = 8'h00;
  localparam logic [CSR_AW-1:0] CMD_PORT_ADDR     = 8'h0C;
  localparam logic [CSR_AW-1:0] RESP_PORT_ADDR    = 8'h10;
  localparam logic [CSR_AW-1:0] QUEUE_STATUS_ADDR = 8'h14;
  localparam logic [CSR_AW-1:0] BUS_TIMING_ADDR   = 8'h18;

  // CTRL fields
  localparam int CTRL_ENABLE = 0;

  // QUEUE_STATUS fields
  localparam int QST_CMD_EMPTY  = 0;
  localparam int QST_CMD_FULL   = 1;
  localparam int QST_RESP_EMPTY = 2;
  localparam int QST_RESP_FULL  = 3;

  // SCL half period in core clocks
  localparam int                       HALF_PERIOD_W    = 16;
  localparam logic [HALF_PERIOD_W-1:0] BUS_TIMING_RESET = 16'd8;
  localparam logic [HALF_PERIOD_W-1:0] BUS_TIMING_MIN   = 16'd4;

endpackage
